// ==== design/matmul_pkg.sv ====
package matmul_pkg;

  ////////////////////
  // Sizes and widths
  ////////////////////

  localparam int N      = 4;
  localparam int DATA_W = 8;
  localparam int ADDR_W = 10;
  localparam int CNT_W  = 6;

  ////////////////////
  // Latencies
  ////////////////////

  // Cycles from an address to its data word
  localparam int MEM_LATENCY = 1;
  // Input flop, product flop and accumulator
  localparam int MAC_STAGES = 3;

  // Last pair enters cell (N-1, N-1) at cycle 3N-1 and is summed MAC_STAGES later
  localparam int DRAIN_START = 3 * N + MEM_LATENCY + MAC_STAGES;
  localparam int DONE_CYCLE  = DRAIN_START + N;

  ////////////////////
  // Payload types
  ////////////////////

  typedef logic signed [DATA_W-1:0] elem_t;
  // Lane 0 sits in the low bits
  typedef elem_t [N-1:0] lanes_t;

endpackage

// ==== design/mac_pe.sv ====
module mac_pe import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  i_clear,
  input  elem_t i_a,
  input  elem_t i_b,
  output elem_t o_a,
  output elem_t o_b,
  output elem_t o_sum
);

  logic signed [2*DATA_W-1:0] prod_q;
  logic [DATA_W:0]            prod_upper;
  elem_t                      prod_sat;

  // Forwarding flops double as the multiplier input stage
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // Full-width signed product
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= (2*DATA_W)'(o_a) * (2*DATA_W)'(o_b);
    end
  end

  ////////////////////
  // Saturation
  ////////////////////

  // Product fits when the bits from the 8-bit sign upward all agree
  assign prod_upper = prod_q[2*DATA_W-1:DATA_W-1];

  always_comb begin
    if (prod_upper == '0 || prod_upper == '1) begin
      prod_sat = prod_q[DATA_W-1:0];
    end else if (prod_q[2*DATA_W-1]) begin
      prod_sat = {1'b1, {(DATA_W-1){1'b0}}};
    end else begin
      prod_sat = {1'b0, {(DATA_W-1){1'b1}}};
    end
  end

  // Accumulator wraps at 8 bits
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_sum <= '0;
    end else begin
      o_sum <= o_sum + prod_sat;
    end
  end

endmodule

// ==== design/operand_feeder.sv ====
module operand_feeder import matmul_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  logic [ADDR_W-1:0] i_base,
  input  lanes_t            i_mem_data,
  output logic [ADDR_W-1:0] o_addr,
  output lanes_t            o_lanes
);

  logic [CNT_W-1:0]       fetch_cnt;
  logic                   fetch;
  logic [MEM_LATENCY-1:0] valid_sr;
  logic                   mem_valid;
  lanes_t                 masked;

  ////////////////////
  // Address generation
  ////////////////////

  // Address steps by N for the first N cycles of a job, then parks again
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      fetch_cnt <= '0;
      fetch     <= 1'b0;
      o_addr    <= i_base - ADDR_W'(N);
    end else if (fetch_cnt < CNT_W'(N)) begin
      fetch_cnt <= fetch_cnt + 1'b1;
      fetch     <= 1'b1;
      // First fetch starts from the base presented with the job
      if (fetch_cnt == '0) begin
        o_addr <= i_base;
      end else begin
        o_addr <= o_addr + ADDR_W'(N);
      end
    end else begin
      fetch  <= 1'b0;
      o_addr <= i_base - ADDR_W'(N);
    end
  end

  // Fetch flag follows the memory by MEM_LATENCY cycles
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= MEM_LATENCY'({valid_sr, fetch});
    end
  end

  assign mem_valid = valid_sr[MEM_LATENCY-1];
  assign masked    = mem_valid ? i_mem_data : '0;

  ////////////////////
  // Lane skew
  ////////////////////

  // Lane i is delayed by i cycles
  for (genvar i = 0; i < N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_lanes[i] = masked[i];
    end else begin : g_delay
      elem_t dly [i];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          for (int d = 0; d < i; d++) begin
            dly[d] <= '0;
          end
        end else begin
          dly[0] <= masked[i];
          for (int d = 1; d < i; d++) begin
            dly[d] <= dly[d-1];
          end
        end
      end

      assign o_lanes[i] = dly[i-1];
    end
  end

endmodule

// ==== design/systolic_array.sv ====
module systolic_array import matmul_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   i_clear,
  input  lanes_t i_a_lanes,
  input  lanes_t i_b_lanes,
  output elem_t  o_sums [N][N]
);

  // a moves right along a row, b moves down a column
  elem_t a_link [N][N+1];
  elem_t b_link [N+1][N];

  ////////////////////
  // Edge inputs
  ////////////////////

  for (genvar k = 0; k < N; k++) begin : g_edge
    assign a_link[k][0] = i_a_lanes[k];
    assign b_link[0][k] = i_b_lanes[k];
  end

  ////////////////////
  // Cell grid
  ////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_link[i][j]),
        .i_b     (b_link[i][j]),
        .o_a     (a_link[i][j+1]),
        .o_b     (b_link[i+1][j]),
        .o_sum   (o_sums[i][j])
      );
    end
  end

endmodule

// ==== design/result_drain.sv ====
module result_drain import matmul_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  logic [ADDR_W-1:0] i_base_c,
  input  elem_t             i_sums [N][N],
  output lanes_t            o_c_data,
  output logic [ADDR_W-1:0] o_c_addr,
  output logic              o_c_valid,
  output logic              o_done
);

  logic [CNT_W-1:0] cycle_cnt;
  logic             in_window;
  lanes_t           col_data;

  // Job cycle counter holds one past DONE_CYCLE so done fires once
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      cycle_cnt <= '0;
    end else if (cycle_cnt <= CNT_W'(DONE_CYCLE)) begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  ////////////////////
  // Column select
  ////////////////////

  always_comb begin
    in_window = 1'b0;
    col_data  = '0;
    for (int j = 0; j < N; j++) begin
      if (cycle_cnt == CNT_W'(DRAIN_START + j)) begin
        in_window = 1'b1;
        for (int i = 0; i < N; i++) begin
          col_data[i] = i_sums[i][j];
        end
      end
    end
  end

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_c_valid <= 1'b0;
      o_c_data  <= '0;
      o_c_addr  <= i_base_c - ADDR_W'(N);
      o_done    <= 1'b0;
    end else begin
      o_done <= (cycle_cnt == CNT_W'(DONE_CYCLE));
      if (in_window) begin
        o_c_valid <= 1'b1;
        o_c_data  <= col_data;
        o_c_addr  <= o_c_addr + ADDR_W'(N);
      end else begin
        // Outside the drain the address parks one step below base
        o_c_valid <= 1'b0;
        o_c_data  <= '0;
        o_c_addr  <= i_base_c - ADDR_W'(N);
      end
    end
  end

endmodule

// ==== design/matmul_tile.sv ====
module matmul_tile import matmul_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  input  logic [ADDR_W-1:0] i_base_a,
  input  logic [ADDR_W-1:0] i_base_b,
  input  logic [ADDR_W-1:0] i_base_c,
  input  lanes_t            i_a_data,
  input  lanes_t            i_b_data,
  output logic [ADDR_W-1:0] o_a_addr,
  output logic [ADDR_W-1:0] o_b_addr,
  output lanes_t            o_c_data,
  output logic [ADDR_W-1:0] o_c_addr,
  output logic              o_c_valid,
  output logic              o_done
);

  logic   clear;
  lanes_t a_lanes;
  lanes_t b_lanes;
  elem_t  sums [N][N];

  // Tile is held clear whenever no job is running
  assign clear = reset | ~i_start;

  ////////////////////
  // Operand fetch
  ////////////////////

  operand_feeder u_feed_a (
    .clk        (clk),
    .reset      (reset),
    .i_clear    (clear),
    .i_base     (i_base_a),
    .i_mem_data (i_a_data),
    .o_addr     (o_a_addr),
    .o_lanes    (a_lanes)
  );

  operand_feeder u_feed_b (
    .clk        (clk),
    .reset      (reset),
    .i_clear    (clear),
    .i_base     (i_base_b),
    .i_mem_data (i_b_data),
    .o_addr     (o_b_addr),
    .o_lanes    (b_lanes)
  );

  ////////////////////
  // Compute and drain
  ////////////////////

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_sums    (sums)
  );

  result_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_base_c  (i_base_c),
    .i_sums    (sums),
    .o_c_data  (o_c_data),
    .o_c_addr  (o_c_addr),
    .o_c_valid (o_c_valid),
    .o_done    (o_done)
  );

endmodule

// ==== verification/matmul_checker.sv ====
module matmul_checker import matmul_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  input  logic [ADDR_W-1:0] i_base_c,
  input  lanes_t            i_exp_cols [N],
  input  logic              i_c_valid,
  input  lanes_t            i_c_data,
  input  logic [ADDR_W-1:0] i_c_addr,
  input  logic              i_done,
  output logic              o_job_done,
  output int                o_value_errors,
  output int                o_proto_errors
);

  int job_cyc    = 0;
  int valid_cnt  = 0;
  int value_errs = 0;
  int proto_errs = 0;

  assign o_value_errors = value_errs;
  assign o_proto_errors = proto_errs;

  // Rising edges seen since the job started
  always @(posedge clk) begin
    if (reset || !i_start) begin
      job_cyc <= 0;
    end else begin
      job_cyc <= job_cyc + 1;
    end
  end

  ////////////////////
  // Output checks
  ////////////////////

  // Outputs move on the rising edge and are compared on the falling one
  always @(negedge clk) begin
    int                col;
    bit                exp_valid;
    bit                exp_done;
    lanes_t            exp_data;
    logic [ADDR_W-1:0] exp_addr;

    col       = job_cyc - 1 - DRAIN_START;
    exp_valid = (col >= 0) && (col < N);
    exp_done  = (job_cyc == DONE_CYCLE + 1);
    exp_data  = '0;
    exp_addr  = '0;
    if (exp_valid) begin
      exp_data = i_exp_cols[col];
      exp_addr = i_base_c + ADDR_W'(N * col);
    end
    if (job_cyc == 0) begin
      valid_cnt  = 0;
      o_job_done = 1'b0;
    end

    if (i_c_valid !== exp_valid) begin
      $display("Protocol error at %0t: o_c_valid is %b but should be %b",
               $time, i_c_valid, exp_valid);
      proto_errs++;
    end
    if (i_done !== exp_done) begin
      $display("Protocol error at %0t: o_done is %b but should be %b", $time, i_done, exp_done);
      proto_errs++;
    end
    // Idle cycles expect all-zero data
    if (i_c_data !== exp_data) begin
      $display("ERROR at %0t: o_c_data expected %h, got %h", $time, exp_data, i_c_data);
      value_errs++;
    end
    if (exp_valid && i_c_addr !== exp_addr) begin
      $display("ERROR at %0t: o_c_addr expected %h, got %h", $time, exp_addr, i_c_addr);
      value_errs++;
    end

    if (i_c_valid === 1'b1) begin
      valid_cnt++;
    end
    if (i_done === 1'b1) begin
      if (valid_cnt != N) begin
        $display("Protocol error at %0t: o_done came after %0d valid columns instead of %0d",
                 $time, valid_cnt, N);
        proto_errs++;
      end
      o_job_done = 1'b1;
    end
  end

endmodule

// ==== verification/tb_matmul.sv ====
module tb_matmul import matmul_pkg::*; ();

  localparam int JOB_TIMEOUT = 100;
  localparam int JOB_VALUES  = 3 + 3 * N * N;

  logic              clk = 1'b0;
  logic              reset;
  logic              start;
  logic [ADDR_W-1:0] base_a;
  logic [ADDR_W-1:0] base_b;
  logic [ADDR_W-1:0] base_c;
  lanes_t            a_rdata = '0;
  lanes_t            b_rdata = '0;
  logic [ADDR_W-1:0] a_addr;
  logic [ADDR_W-1:0] b_addr;
  lanes_t            c_data;
  logic [ADDR_W-1:0] c_addr;
  logic              c_valid;
  logic              done;

  lanes_t a_mem [2**ADDR_W];
  lanes_t b_mem [2**ADDR_W];
  lanes_t exp_cols [N] = '{default: '0};

  logic job_done;
  int   value_errors;
  int   proto_errors;
  int   fd;
  int   job_count;
  bit   timed_out;
  bit   file_error;

  always #10 clk = ~clk;

  // Both memories answer one cycle after the address
  always @(posedge clk) begin
    a_rdata <= a_mem[a_addr];
    b_rdata <= b_mem[b_addr];
  end

  matmul_tile uut (
    .clk       (clk),
    .reset     (reset),
    .i_start   (start),
    .i_base_a  (base_a),
    .i_base_b  (base_b),
    .i_base_c  (base_c),
    .i_a_data  (a_rdata),
    .i_b_data  (b_rdata),
    .o_a_addr  (a_addr),
    .o_b_addr  (b_addr),
    .o_c_data  (c_data),
    .o_c_addr  (c_addr),
    .o_c_valid (c_valid),
    .o_done    (done)
  );

  matmul_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .i_start        (start),
    .i_base_c       (base_c),
    .i_exp_cols     (exp_cols),
    .i_c_valid      (c_valid),
    .i_c_data       (c_data),
    .i_c_addr       (c_addr),
    .i_done         (done),
    .o_job_done     (job_done),
    .o_value_errors (value_errors),
    .o_proto_errors (proto_errors)
  );

  ////////////////////
  // Stimulus file
  ////////////////////

  // Reads the next hex token and skips comment lines
  task automatic next_hex(output logic [31:0] value, output bit ok);
    string tok;
    string rest;
    int    code;
    ok    = 1'b0;
    value = '0;
    code  = $fscanf(fd, "%s", tok);
    while (code == 1 && tok.substr(0, 1) == "//") begin
      code = $fgets(rest, fd);
      code = $fscanf(fd, "%s", tok);
    end
    if (code == 1) begin
      ok = ($sscanf(tok, "%h", value) == 1);
    end
  endtask

  // Bases, then A, B and C row by row
  task automatic load_job(output bit ok);
    logic [31:0] vals [JOB_VALUES];
    int          count;
    bit          got;
    count = 0;
    got   = 1'b1;
    while (got && count < JOB_VALUES) begin
      next_hex(vals[count], got);
      if (got) begin
        count++;
      end
    end
    ok = (count == JOB_VALUES);
    if (count != 0 && !ok) begin
      $display("Stimulus file ends inside a job after %0d values", count);
      file_error = 1'b1;
    end
    if (ok) begin
      base_a = ADDR_W'(vals[0]);
      base_b = ADDR_W'(vals[1]);
      base_c = ADDR_W'(vals[2]);
      for (int r = 0; r < N; r++) begin
        for (int s = 0; s < N; s++) begin
          // Word k of A holds column k, word k of B holds row k
          a_mem[ADDR_W'(base_a + N * s)][r] = elem_t'(vals[3 + r * N + s]);
          b_mem[ADDR_W'(base_b + N * r)][s] = elem_t'(vals[3 + N * N + r * N + s]);
          exp_cols[s][r] = elem_t'(vals[3 + 2 * N * N + r * N + s]);
        end
      end
    end
  endtask

  ////////////////////
  // Job sequencing
  ////////////////////

  task automatic run_job();
    int waited;
    start  = 1'b1;
    waited = 0;
    while (!job_done && waited < JOB_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!job_done) begin
      $display("Job %0d did not raise o_done within %0d cycles", job_count, JOB_TIMEOUT);
      timed_out = 1'b1;
    end
    @(negedge clk);
    start = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  initial begin
    bit have_job;
    bit stop;
    reset      = 1'b1;
    start      = 1'b0;
    base_a     = '0;
    base_b     = '0;
    base_c     = '0;
    job_count  = 0;
    timed_out  = 1'b0;
    file_error = 1'b0;
    // Background words that the feeders must mask out
    for (int a = 0; a < 2**ADDR_W; a++) begin
      a_mem[a] = lanes_t'(32'h9e37_79b1 * a);
      b_mem[a] = lanes_t'(32'h85eb_ca6b * a + 32'h1b87_3593);
    end
    fd = $fopen("verification/matmul_stimulus.txt", "r");
    repeat (3) @(negedge clk);
    reset = 1'b0;

    if (fd == 0) begin
      $display("Cannot open verification/matmul_stimulus.txt");
      file_error = 1'b1;
    end else begin
      stop = 1'b0;
      while (!stop) begin
        load_job(have_job);
        if (have_job) begin
          run_job();
          job_count++;
        end
        stop = !have_job || timed_out || file_error;
      end
      $fclose(fd);
    end
    if (job_count == 0) begin
      $display("No job was run");
    end

    @(posedge clk);
    $display("Jobs: %0d  value errors: %0d  protocol errors: %0d",
             job_count, value_errors, proto_errors);
    if (timed_out || file_error || job_count == 0 || value_errors != 0 || proto_errors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

// ==== verification/matmul_stimulus.txt ====
// Each job is one line of bases for A, B and C and three lines of 16 hex bytes
// The byte lines hold A, B and the expected C, each row by row
// Identity A returns B
000 040 080
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
05 fb 7f 80 12 00 c3 3a ff 01 64 9c 27 d8 0e 71
05 fb 7f 80 12 00 c3 3a ff 01 64 9c 27 d8 0e 71
// Mixed signs with products clipped to the 8-bit range
100 140 1c0
10 00 00 00 00 f0 00 00 00 00 03 00 00 00 00 c0
09 f7 07 f8 08 f8 09 f9 2a d6 2b 2a 02 fe 01 03
7f 80 70 80 80 7f 80 70 7e 82 7f 7e 80 7f c0 80
// Sums of clipped products that wrap
3f0 0a4 2f8
7f 7f 7f 7f 80 80 80 80 40 40 40 c0 01 02 03 04
01 02 ff 10 01 02 ff 10 01 02 ff 10 01 02 ff 00
fc fc 04 7d 00 00 fc 80 80 fd 80 7d 0a 14 f6 60
// Same job as the second one after a restart
100 140 1c0
10 00 00 00 00 f0 00 00 00 00 03 00 00 00 00 c0
09 f7 07 f8 08 f8 09 f9 2a d6 2b 2a 02 fe 01 03
7f 80 70 80 80 7f 80 70 7e 82 7f 7e 80 7f c0 80
// New bases with identity B returning A
080 2c0 004
81 7e 00 33 c8 19 f2 05 6a 95 ee 40 0f e1 7f 88
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
81 7e 00 33 c8 19 f2 05 6a 95 ee 40 0f e1 7f 88

// ==== all.f ====
design/matmul_pkg.sv
design/mac_pe.sv
design/operand_feeder.sv
design/systolic_array.sv
design/result_drain.sv
design/matmul_tile.sv
verification/matmul_checker.sv
verification/tb_matmul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_matmul -Mdir obj_dir
output=$(./obj_dir/Vtb_matmul)
echo "$output"
if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
